/* hw/descriptor_fetch.sv */
// Descriptor fetch read master
`timescale 1ns/1ps
`default_nettype none

module descriptor_fetch (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        enable,
  input  dma_frontend_pkg::addr_t     start_location,
  input  logic                        load_start,
  output dma_frontend_pkg::addr_t     fetch_address,
  output logic                        fetch_read,
  input  dma_frontend_pkg::desc_t     fetch_readdata,
  input  logic                        fetch_readdatavalid,
  input  logic                        fetch_waitrequest,
  output dma_frontend_pkg::cmd_t      cmd_data,
  output logic                        cmd_valid,
  input  logic                        cmd_ready,
  output logic                        queue_push,
  output dma_frontend_pkg::wb_entry_t queue_entry,
  input  logic                        queue_full,
  output dma_frontend_pkg::addr_t     fetch_location,
  output logic                        fetch_idle
);

  dma_frontend_pkg::fetch_state_t state;
  // descriptor held while it waits for both sinks
  dma_frontend_pkg::desc_t        desc_q;

  // one read at a time, always from the current location
  assign fetch_address = fetch_location;
  assign fetch_read    = (state == dma_frontend_pkg::FETCH_READ);
  assign fetch_idle    = (state == dma_frontend_pkg::FETCH_IDLE);

  // the dispatcher and the write-back queue take the descriptor in the same cycle
  assign cmd_valid   = (state == dma_frontend_pkg::FETCH_PRESENT) && cmd_ready && !queue_full;
  assign queue_push  = cmd_valid;
  assign queue_entry = {desc_q[127:96], fetch_location};

  // command order from low to high is length, destination, source
  assign cmd_data = {desc_q[31:0], desc_q[63:32], desc_q[95:64]};

  always_ff @(posedge clk)
  begin
    if ((state == dma_frontend_pkg::FETCH_WAIT_DATA) && fetch_readdatavalid)
    begin
      desc_q <= fetch_readdata;
    end
  end

  // **************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= dma_frontend_pkg::FETCH_IDLE;
      fetch_location <= '0;
    end
    else
    begin
      case (state)
        dma_frontend_pkg::FETCH_IDLE:
        begin
          // a new start location is taken even while disabled
          if (load_start)
          begin
            fetch_location <= start_location;
            if (enable)
            begin
              state <= dma_frontend_pkg::FETCH_READ;
            end
          end
        end
        dma_frontend_pkg::FETCH_READ:
        begin
          if (!fetch_waitrequest)
          begin
            state <= dma_frontend_pkg::FETCH_WAIT_DATA;
          end
        end
        dma_frontend_pkg::FETCH_WAIT_DATA:
        begin
          // a host-owned descriptor stops the chain and the location stays on it
          if (fetch_readdatavalid)
          begin
            if (fetch_readdata[dma_frontend_pkg::CTRL_OWNED_BIT])
            begin
              state <= dma_frontend_pkg::FETCH_PRESENT;
            end
            else
            begin
              state <= dma_frontend_pkg::FETCH_IDLE;
            end
          end
        end
        default:
        begin
          if (cmd_valid)
          begin
            fetch_location <= fetch_location + dma_frontend_pkg::addr_t'(dma_frontend_pkg::DESC_BYTES);
            state <= enable ? dma_frontend_pkg::FETCH_READ : dma_frontend_pkg::FETCH_IDLE;
          end
        end
      endcase
    end
  end

  // a read request is held with its address until memory takes it
  assert property (@(posedge clk) disable iff (reset)
    (fetch_read && fetch_waitrequest) |=> (fetch_read && $stable(fetch_address)));

endmodule

`default_nettype wire

/* hw/descriptor_writeback.sv */
// Descriptor write-back master
`timescale 1ns/1ps
`default_nettype none

module descriptor_writeback (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        irq_mask,
  input  logic                        clear_irq,
  input  logic                        queue_push,
  input  dma_frontend_pkg::wb_entry_t queue_entry,
  output logic                        queue_full,
  input  dma_frontend_pkg::resp_t     resp_data,
  input  logic                        resp_valid,
  output logic                        resp_ready,
  output dma_frontend_pkg::addr_t     store_address,
  output logic                        store_write,
  output dma_frontend_pkg::desc_t     store_writedata,
  input  logic                        store_waitrequest,
  output dma_frontend_pkg::addr_t     store_location,
  output logic                        irq
);

  dma_frontend_pkg::wb_state_t state;
  dma_frontend_pkg::wb_entry_t head;
  dma_frontend_pkg::desc_t     wb_word;
  logic                        queue_empty;
  logic                        resp_accept;

  // addresses of presented descriptors, oldest at the head
  sync_fifo #(
    .WIDTH      (dma_frontend_pkg::ENTRY_W),
    .DEPTH_LOG2 (dma_frontend_pkg::WB_QUEUE_DEPTH_LOG2)
  ) wb_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (queue_push),
    .push_data (queue_entry),
    .pop       (resp_accept),
    .pop_data  (head),
    .full      (queue_full),
    .empty     (queue_empty)
  );

  // a response is taken only when it has an address to go to
  assign resp_ready  = (state == dma_frontend_pkg::WB_IDLE) && !queue_empty;
  assign resp_accept = resp_valid && resp_ready;
  assign store_write = (state == dma_frontend_pkg::WB_WRITE);

  // status word with the original control bits and ownership handed back to the host
  always_comb
  begin
    wb_word          = '0;
    wb_word[40:0]    = resp_data[40:0];
    wb_word[127:96]  = head[63:32];
    wb_word[dma_frontend_pkg::CTRL_OWNED_BIT] = 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (resp_accept)
    begin
      store_address   <= head[31:0];
      store_writedata <= wb_word;
    end
  end

  // **************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= dma_frontend_pkg::WB_IDLE;
      store_location <= '0;
      irq            <= 1'b0;
    end
    else
    begin
      if (clear_irq)
      begin
        irq <= 1'b0;
      end
      if (resp_accept)
      begin
        state <= dma_frontend_pkg::WB_WRITE;
      end
      else if (store_write && !store_waitrequest)
      begin
        state          <= dma_frontend_pkg::WB_IDLE;
        store_location <= store_address;
        // a new completion wins over a clear in the same cycle
        if (store_writedata[dma_frontend_pkg::CTRL_IRQ_BIT] && irq_mask)
        begin
          irq <= 1'b1;
        end
      end
    end
  end

  // every pop must find an entry that the fetch engine pushed earlier
  assert property (@(posedge clk) disable iff (reset) resp_accept |-> !queue_empty);

endmodule

`default_nettype wire

/* hw/dma_csr.sv */
// Frontend control and status registers
`timescale 1ns/1ps
`default_nettype none

module dma_csr (
  input  logic                        clk,
  input  logic                        reset,
  input  dma_frontend_pkg::reg_addr_t reg_address,
  input  logic                        reg_read,
  output dma_frontend_pkg::reg_data_t reg_readdata,
  input  logic                        reg_write,
  input  dma_frontend_pkg::reg_data_t reg_writedata,
  input  logic [7:0]                  reg_byteenable,
  input  dma_frontend_pkg::addr_t     fetch_location,
  input  dma_frontend_pkg::addr_t     store_location,
  input  logic                        fetch_idle,
  input  logic                        irq,
  output logic                        enable,
  output logic                        irq_mask,
  output dma_frontend_pkg::addr_t     start_location,
  output logic                        load_start,
  output logic                        clear_irq
);

  // **************************************************
  // control word, only byte lane 0 holds live bits
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enable   <= 1'b0;
      irq_mask <= 1'b0;
    end
    else if (reg_write && (reg_address == dma_frontend_pkg::REG_CONTROL) && reg_byteenable[0])
    begin
      enable   <= reg_writedata[0];
      irq_mask <= reg_writedata[2];
    end
  end

  // start location is written per byte lane, lanes above 3 hold nothing
  always_ff @(posedge clk)
  begin
    if (reg_write && (reg_address == dma_frontend_pkg::REG_START))
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (reg_byteenable[i])
        begin
          start_location[8*i +: 8] <= reg_writedata[8*i +: 8];
        end
      end
    end
  end

  // **************************************************
  // the most significant lane of the start word commits the new location
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      load_start <= 1'b0;
      clear_irq  <= 1'b0;
    end
    else
    begin
      load_start <= reg_write && (reg_address == dma_frontend_pkg::REG_START) &&
                    reg_byteenable[7];
      clear_irq  <= reg_write && (reg_address == dma_frontend_pkg::REG_STATUS) &&
                    reg_byteenable[0] && reg_writedata[0];
    end
  end

  // readback is registered, data is valid the cycle after reg_read
  always_ff @(posedge clk)
  begin
    if (reg_read)
    begin
      case (reg_address)
        dma_frontend_pkg::REG_CONTROL:   reg_readdata <= {61'd0, irq_mask, 1'b0, enable};
        dma_frontend_pkg::REG_START:     reg_readdata <= {32'd0, start_location};
        dma_frontend_pkg::REG_FETCH_LOC: reg_readdata <= {32'd0, fetch_location};
        dma_frontend_pkg::REG_STORE_LOC: reg_readdata <= {32'd0, store_location};
        dma_frontend_pkg::REG_STATUS:    reg_readdata <= {62'd0, fetch_idle, irq};
        default:                         reg_readdata <= '0;
      endcase
    end
  end

  // both strobes decode distinct indices of a single write
  assert property (@(posedge clk) disable iff (reset) !(load_start && clear_irq));

endmodule

`default_nettype wire

/* hw/dma_frontend.sv */
// DMA descriptor frontend top level
`timescale 1ns/1ps
`default_nettype none

module dma_frontend (
  input  logic                        clk,
  input  logic                        reset,
  input  dma_frontend_pkg::reg_addr_t reg_address,
  input  logic                        reg_read,
  output dma_frontend_pkg::reg_data_t reg_readdata,
  input  logic                        reg_write,
  input  dma_frontend_pkg::reg_data_t reg_writedata,
  input  logic [7:0]                  reg_byteenable,
  output logic                        irq,
  output dma_frontend_pkg::addr_t     fetch_address,
  output logic                        fetch_read,
  input  dma_frontend_pkg::desc_t     fetch_readdata,
  input  logic                        fetch_readdatavalid,
  input  logic                        fetch_waitrequest,
  output dma_frontend_pkg::cmd_t      cmd_data,
  output logic                        cmd_valid,
  input  logic                        cmd_ready,
  input  dma_frontend_pkg::resp_t     resp_data,
  input  logic                        resp_valid,
  output logic                        resp_ready,
  output dma_frontend_pkg::addr_t     store_address,
  output logic                        store_write,
  output dma_frontend_pkg::desc_t     store_writedata,
  input  logic                        store_waitrequest
);

  logic                        enable;
  logic                        irq_mask;
  logic                        load_start;
  logic                        clear_irq;
  logic                        fetch_idle;
  dma_frontend_pkg::addr_t     start_location;
  dma_frontend_pkg::addr_t     fetch_location;
  dma_frontend_pkg::addr_t     store_location;
  // write-back queue handoff between the engines
  logic                        queue_push;
  logic                        queue_full;
  dma_frontend_pkg::wb_entry_t queue_entry;

  dma_csr csr (
    .clk            (clk),
    .reset          (reset),
    .reg_address    (reg_address),
    .reg_read       (reg_read),
    .reg_readdata   (reg_readdata),
    .reg_write      (reg_write),
    .reg_writedata  (reg_writedata),
    .reg_byteenable (reg_byteenable),
    .fetch_location (fetch_location),
    .store_location (store_location),
    .fetch_idle     (fetch_idle),
    .irq            (irq),
    .enable         (enable),
    .irq_mask       (irq_mask),
    .start_location (start_location),
    .load_start     (load_start),
    .clear_irq      (clear_irq)
  );

  descriptor_fetch fetch (
    .clk                 (clk),
    .reset               (reset),
    .enable              (enable),
    .start_location      (start_location),
    .load_start          (load_start),
    .fetch_address       (fetch_address),
    .fetch_read          (fetch_read),
    .fetch_readdata      (fetch_readdata),
    .fetch_readdatavalid (fetch_readdatavalid),
    .fetch_waitrequest   (fetch_waitrequest),
    .cmd_data            (cmd_data),
    .cmd_valid           (cmd_valid),
    .cmd_ready           (cmd_ready),
    .queue_push          (queue_push),
    .queue_entry         (queue_entry),
    .queue_full          (queue_full),
    .fetch_location      (fetch_location),
    .fetch_idle          (fetch_idle)
  );

  descriptor_writeback writeback (
    .clk               (clk),
    .reset             (reset),
    .irq_mask          (irq_mask),
    .clear_irq         (clear_irq),
    .queue_push        (queue_push),
    .queue_entry       (queue_entry),
    .queue_full        (queue_full),
    .resp_data         (resp_data),
    .resp_valid        (resp_valid),
    .resp_ready        (resp_ready),
    .store_address     (store_address),
    .store_write       (store_write),
    .store_writedata   (store_writedata),
    .store_waitrequest (store_waitrequest),
    .store_location    (store_location),
    .irq               (irq)
  );

endmodule

`default_nettype wire

/* hw/dma_frontend_pkg.sv */
// DMA descriptor frontend definitions
`default_nettype none

package dma_frontend_pkg;

  // memory side widths
  localparam int ADDR_W     = 32;
  localparam int DESC_W     = 128;
  localparam int DESC_BYTES = 16;
  localparam int CMD_W      = 96;
  localparam int RESP_W     = 64;

  // a write-back queue entry is the descriptor address with its control word above it
  localparam int ENTRY_W = ADDR_W + 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DESC_W-1:0]  desc_t;
  typedef logic [CMD_W-1:0]   cmd_t;
  typedef logic [RESP_W-1:0]  resp_t;
  typedef logic [ENTRY_W-1:0] wb_entry_t;
  typedef logic [63:0]        reg_data_t;
  typedef logic [2:0]         reg_addr_t;

  // register slave map, one 64-bit word per index
  localparam reg_addr_t REG_CONTROL   = 3'd0;
  localparam reg_addr_t REG_START     = 3'd1;
  localparam reg_addr_t REG_FETCH_LOC = 3'd2;
  localparam reg_addr_t REG_STORE_LOC = 3'd3;
  localparam reg_addr_t REG_STATUS    = 3'd4;

  // bit positions inside the descriptor control word
  localparam int CTRL_IRQ_BIT   = 96;
  localparam int CTRL_OWNED_BIT = 127;

  // write-back queue holds four descriptors
  localparam int WB_QUEUE_DEPTH_LOG2 = 2;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_READ, FETCH_WAIT_DATA, FETCH_PRESENT} fetch_state_t;
  typedef enum logic {WB_IDLE, WB_WRITE} wb_state_t;

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
// Synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             full,
  output logic             empty
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // one extra bit so a full array can be told apart from an empty one
  logic [DEPTH_LOG2:0]   count;

  // the head entry is visible before it is popped
  assign pop_data = mem[rd_ptr];
  assign full     = (count == (DEPTH_LOG2+1)'(2**DEPTH_LOG2));
  assign empty    = (count == '0);

  always_ff @(posedge clk)
  begin
    if (push && !full)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap naturally at the array size
      if (push && !full)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (DEPTH_LOG2+1)'(push && !full) - (DEPTH_LOG2+1)'(pop && !empty);
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DMA frontend simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dma_frontend \
  -f verilog.f --Mdir obj_dir -o sim_dma_frontend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dma_frontend > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* test/frontend_checker.sv */
// Frontend response checker
`timescale 1ns/1ps
`default_nettype none

module frontend_checker (
  input wire logic                        clk,
  input wire logic                        reset,
  input wire dma_frontend_pkg::reg_addr_t reg_address,
  input wire logic                        reg_read,
  input wire dma_frontend_pkg::reg_data_t reg_readdata,
  input wire logic                        reg_write,
  input wire dma_frontend_pkg::reg_data_t reg_writedata,
  input wire logic [7:0]                  reg_byteenable,
  input wire logic                        irq,
  input wire dma_frontend_pkg::addr_t     fetch_address,
  input wire logic                        fetch_read,
  input wire logic                        fetch_waitrequest,
  input wire dma_frontend_pkg::desc_t     fetch_readdata,
  input wire logic                        fetch_readdatavalid,
  input wire dma_frontend_pkg::cmd_t      cmd_data,
  input wire logic                        cmd_valid,
  input wire logic                        cmd_ready,
  input wire dma_frontend_pkg::resp_t     resp_data,
  input wire logic                        resp_valid,
  input wire logic                        resp_ready,
  input wire dma_frontend_pkg::addr_t     store_address,
  input wire logic                        store_write,
  input wire dma_frontend_pkg::desc_t     store_writedata,
  input wire logic                        store_waitrequest
);

  int    error_count = 0;
  int    check_count = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    errors_at_start = 0;
  string cur_test = "reset";

  // register model kept from the host writes
  logic                    m_enable;
  logic                    m_mask;
  dma_frontend_pkg::addr_t m_start;
  dma_frontend_pkg::addr_t m_store_loc;
  dma_frontend_pkg::addr_t exp_fetch_addr;
  logic                    m_busy;
  logic                    exp_irq;
  logic                    clear_pending;
  logic                    irq_set;
  logic                    rd_pending;
  dma_frontend_pkg::reg_data_t rd_exp;

  // expected traffic, oldest first
  dma_frontend_pkg::cmd_t  cmd_q[$];
  logic [31:0]             ctrl_q[$];
  logic [31:0]             pend_ctrl_q[$];
  dma_frontend_pkg::addr_t wb_addr_q[$];
  dma_frontend_pkg::resp_t resp_q[$];
  logic [31:0]             ctrl;
  dma_frontend_pkg::addr_t addr;

  // dispatcher command is length at the bottom, then destination, then source
  function automatic dma_frontend_pkg::cmd_t expected_command(input dma_frontend_pkg::desc_t d);
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] len;
    src = d[31:0];
    dst = d[63:32];
    len = d[95:64];
    return {src, dst, len};
  endfunction

  // status word handed back to the host, ownership bit cleared
  function automatic dma_frontend_pkg::desc_t expected_writeback(input logic [31:0] c,
                                                               input dma_frontend_pkg::resp_t r);
    dma_frontend_pkg::desc_t w;
    w = '0;
    w[31:0] = r[31:0];
    w[39:32] = r[39:32];
    w[40] = r[40];
    w[126:96] = c[30:0];
    return w;
  endfunction

  task automatic compare(input string what, input logic [127:0] exp, input logic [127:0] act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_error(input string text);
    error_count++;
    $display("error in %s: %s", cur_test, text);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    if (error_count == errors_at_start)
    begin
      tests_passed++;
      $display("test %s: pass", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", cur_test, error_count - errors_at_start);
    end
  endtask

  // anything left over means a descriptor never completed
  task automatic final_checks();
    if (cmd_q.size() != 0 || wb_addr_q.size() != 0 || resp_q.size() != 0)
    begin
      report_error("descriptors were left without a command or a write-back");
    end
  endtask

  // **************************************************
  always @(posedge clk)
  begin
    if (reset)
    begin
      m_enable = 1'b0;
      m_mask = 1'b0;
      m_start = '0;
      m_store_loc = '0;
      exp_fetch_addr = '0;
      m_busy = 1'b0;
      exp_irq = 1'b0;
      clear_pending = 1'b0;
      rd_pending = 1'b0;
      cmd_q.delete();
      ctrl_q.delete();
      pend_ctrl_q.delete();
      wb_addr_q.delete();
      resp_q.delete();
    end
    else
    begin
      irq_set = 1'b0;
      compare("irq", 128'(exp_irq), 128'(irq));
      // a response is taken only with a queued address and no write in progress
      compare("resp_ready", 128'((resp_q.size() == 0) && (wb_addr_q.size() != 0)),
              128'(resp_ready));
      if (rd_pending)
      begin
        compare("readback", 128'(rd_exp), 128'(reg_readdata));
      end
      rd_pending = reg_read;
      case (reg_address)
        dma_frontend_pkg::REG_CONTROL:   rd_exp = {61'd0, m_mask, 1'b0, m_enable};
        dma_frontend_pkg::REG_START:     rd_exp = {32'd0, m_start};
        dma_frontend_pkg::REG_FETCH_LOC: rd_exp = {32'd0, exp_fetch_addr};
        dma_frontend_pkg::REG_STORE_LOC: rd_exp = {32'd0, m_store_loc};
        dma_frontend_pkg::REG_STATUS:    rd_exp = {62'd0, !m_busy, exp_irq};
        default:                         rd_exp = '0;
      endcase

      // fetch reads must walk the chain in 16 byte steps
      if (fetch_read && !fetch_waitrequest)
      begin
        compare("fetch address", 128'(exp_fetch_addr), 128'(fetch_address));
      end
      if (fetch_readdatavalid)
      begin
        if (fetch_readdata[dma_frontend_pkg::CTRL_OWNED_BIT])
        begin
          cmd_q.push_back(expected_command(fetch_readdata));
          pend_ctrl_q.push_back(fetch_readdata[127:96]);
        end
        else
        begin
          m_busy = 1'b0;
        end
      end
      if (cmd_valid && !cmd_ready)
      begin
        report_error("command valid while the dispatcher was not ready");
      end
      if (cmd_valid)
      begin
        if (cmd_q.size() == 0)
        begin
          report_error("command issued without an owned descriptor");
        end
        else
        begin
          compare("command", 128'(cmd_q.pop_front()), 128'(cmd_data));
          wb_addr_q.push_back(exp_fetch_addr);
          ctrl_q.push_back(pend_ctrl_q.pop_front());
        end
        exp_fetch_addr = exp_fetch_addr + 32'd16;
        if (!m_enable)
        begin
          m_busy = 1'b0;
        end
      end
      if (resp_valid && resp_ready)
      begin
        resp_q.push_back(resp_data);
      end
      if (store_write && !store_waitrequest)
      begin
        if (wb_addr_q.size() == 0 || resp_q.size() == 0)
        begin
          report_error("store write with no pending descriptor");
        end
        else
        begin
          addr = wb_addr_q.pop_front();
          ctrl = ctrl_q.pop_front();
          compare("write-back address", 128'(addr), 128'(store_address));
          compare("write-back data", 128'(expected_writeback(ctrl, resp_q.pop_front())),
                  128'(store_writedata));
          m_store_loc = addr;
          irq_set = ctrl[0] && m_mask;
        end
      end

      // clear takes one cycle to reach the flag, a completion wins
      if (clear_pending)
      begin
        exp_irq = 1'b0;
      end
      if (irq_set)
      begin
        exp_irq = 1'b1;
      end
      clear_pending = reg_write && (reg_address == dma_frontend_pkg::REG_STATUS) &&
                      reg_byteenable[0] && reg_writedata[0];
      if (reg_write && (reg_address == dma_frontend_pkg::REG_CONTROL) && reg_byteenable[0])
      begin
        m_enable = reg_writedata[0];
        m_mask = reg_writedata[2];
      end
      if (reg_write && (reg_address == dma_frontend_pkg::REG_START))
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (reg_byteenable[i])
          begin
            m_start[8*i +: 8] = reg_writedata[8*i +: 8];
          end
        end
        if (reg_byteenable[7])
        begin
          exp_fetch_addr = m_start;
          m_busy = m_enable;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_dma_frontend.sv */
// DMA frontend testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dma_frontend;

  localparam int CLK_PERIOD = 40;
  localparam int SEED = 90206;
  // both chains together, and a generous cycle bound for each descriptor
  localparam int NUM_DESC = 11;
  localparam int CYCLES_PER_DESC = 300;
  localparam int TIMEOUT_CYCLES = NUM_DESC * CYCLES_PER_DESC + 1000;

  logic                        clk;
  logic                        reset;
  dma_frontend_pkg::reg_addr_t reg_address;
  logic                        reg_read;
  dma_frontend_pkg::reg_data_t reg_readdata;
  logic                        reg_write;
  dma_frontend_pkg::reg_data_t reg_writedata;
  logic [7:0]                  reg_byteenable;
  logic                        irq;
  dma_frontend_pkg::addr_t     fetch_address;
  logic                        fetch_read;
  dma_frontend_pkg::desc_t     fetch_readdata;
  logic                        fetch_readdatavalid;
  logic                        fetch_waitrequest;
  dma_frontend_pkg::cmd_t      cmd_data;
  logic                        cmd_valid;
  logic                        cmd_ready;
  dma_frontend_pkg::resp_t     resp_data;
  logic                        resp_valid;
  logic                        resp_ready;
  dma_frontend_pkg::addr_t     store_address;
  logic                        store_write;
  dma_frontend_pkg::desc_t     store_writedata;
  logic                        store_waitrequest;

  // descriptor memory, 16 bytes per entry
  dma_frontend_pkg::desc_t     mem [128];
  logic                        rd_pending;
  dma_frontend_pkg::addr_t     rd_addr;
  int                          rd_wait;
  int                          cmd_count;
  int                          resp_sent;
  int                          resp_gap;
  int                          store_count;
  logic                        resp_taken;
  dma_frontend_pkg::reg_data_t rdata;

  dma_frontend UUT (.*);

  frontend_checker chk (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // memory model with random waitrequest and read latency
  always @(negedge clk)
  begin
    fetch_readdatavalid = 1'b0;
    if (rd_pending)
    begin
      if (rd_wait == 0)
      begin
        fetch_readdata = mem[rd_addr[10:4]];
        fetch_readdatavalid = 1'b1;
        rd_pending = 1'b0;
      end
      else
      begin
        rd_wait--;
      end
    end
    fetch_waitrequest = ($urandom_range(0, 2) == 0);
    store_waitrequest = ($urandom_range(0, 2) == 0);
    // fetch_read is stable here, so the request is taken at the next rising edge
    if (fetch_read && !fetch_waitrequest)
    begin
      rd_pending = 1'b1;
      rd_addr = fetch_address;
      rd_wait = $urandom_range(0, 3);
    end
  end

  // dispatcher model, one response per command after a random gap
  always @(negedge clk)
  begin
    cmd_ready = ($urandom_range(0, 3) != 0);
    if (resp_valid && resp_taken)
    begin
      resp_valid = 1'b0;
    end
    if (!resp_valid && (resp_sent < cmd_count))
    begin
      if (resp_gap == 0)
      begin
        resp_data = {$urandom(), $urandom()};
        resp_valid = 1'b1;
        resp_sent++;
        resp_gap = $urandom_range(0, 4);
      end
      else
      begin
        resp_gap--;
      end
    end
  end

  always @(posedge clk)
  begin
    resp_taken = resp_valid && resp_ready;
    if (cmd_valid)
    begin
      cmd_count++;
    end
    if (store_write && !store_waitrequest)
    begin
      store_count++;
    end
  end

  task automatic write_reg(input dma_frontend_pkg::reg_addr_t a,
                           input dma_frontend_pkg::reg_data_t d, input logic [7:0] be);
    @(negedge clk);
    reg_address = a;
    reg_writedata = d;
    reg_byteenable = be;
    reg_write = 1'b1;
    @(negedge clk);
    reg_write = 1'b0;
  endtask

  task automatic read_reg(input dma_frontend_pkg::reg_addr_t a,
                          output dma_frontend_pkg::reg_data_t d);
    @(negedge clk);
    reg_address = a;
    reg_read = 1'b1;
    @(negedge clk);
    reg_read = 0;
    d = reg_readdata;
  endtask

  // owned descriptors followed by one that the host still owns
  // only the last owned descriptor asks for an interrupt unless all of them do
  task automatic build_chain(input int base, input int n, input logic all_irq);
    logic [31:0] c;
    for (int i = 0; i <= n; i++)
    begin
      c = $urandom();
      c[31] = (i < n);
      c[0] = all_irq || (i == n - 1);
      mem[(base >> 4) + i] = {c, $urandom(), $urandom(), $urandom()};
    end
  endtask

  // wait for every write-back, then poll status until fetch reports idle
  task automatic wait_chain_done(input int target);
    while (store_count < target)
    begin
      @(negedge clk);
    end
    rdata = '0;
    while (!rdata[1])
    begin
      read_reg(dma_frontend_pkg::REG_STATUS, rdata);
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    reset = 1'b1;
    reg_address = '0;
    reg_read = 1'b0;
    reg_write = 1'b0;
    reg_writedata = '0;
    reg_byteenable = '0;
    fetch_readdata = '0;
    fetch_readdatavalid = 1'b0;
    fetch_waitrequest = 1'b1;
    cmd_ready = 1'b0;
    resp_data = '0;
    resp_valid = 1'b0;
    store_waitrequest = 1'b1;
    rd_pending = 1'b0;
    rd_addr = '0;
    rd_wait = 0;
    cmd_count = 0;
    resp_sent = 0;
    resp_gap = 0;
    store_count = 0;
    resp_taken = 1'b0;
    // unused entries are host owned and carry their own address
    for (int i = 0; i < 128; i++)
    begin
      mem[i] = {32'h0000_0000, 32'(i * 16) ^ 32'h5a5a_0000, ~32'(i * 16), 32'(i * 16)};
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    chk.start_test("registers");
    write_reg(dma_frontend_pkg::REG_CONTROL, 64'h5, 8'h01);
    write_reg(dma_frontend_pkg::REG_CONTROL, 64'h0, 8'hfe);
    write_reg(dma_frontend_pkg::REG_START, 64'h0000_0000_1111_2222, 8'h0f);
    write_reg(dma_frontend_pkg::REG_START, 64'hdead_beef_3456_789a, 8'h05);
    read_reg(dma_frontend_pkg::REG_CONTROL, rdata);
    read_reg(dma_frontend_pkg::REG_START, rdata);
    read_reg(dma_frontend_pkg::REG_STORE_LOC, rdata);
    for (int i = 5; i < 8; i++)
    begin
      read_reg(dma_frontend_pkg::reg_addr_t'(i), rdata);
    end
    chk.end_test();

    chk.start_test("fetch_chain");
    build_chain(32'h100, 6, 1'b0);
    write_reg(dma_frontend_pkg::REG_START, 64'h100, 8'hff);
    wait_chain_done(6);
    chk.end_test();

    chk.start_test("ownership_stop");
    read_reg(dma_frontend_pkg::REG_STATUS, rdata);
    read_reg(dma_frontend_pkg::REG_FETCH_LOC, rdata);
    read_reg(dma_frontend_pkg::REG_STORE_LOC, rdata);
    chk.end_test();

    // the last owned descriptor of the first chain raised the interrupt while the mask was set
    chk.start_test("interrupt");
    write_reg(dma_frontend_pkg::REG_STATUS, 64'h1, 8'h01);
    repeat (3) @(negedge clk);
    write_reg(dma_frontend_pkg::REG_CONTROL, 64'h1, 8'h01);
    build_chain(32'h400, 3, 1'b1);
    write_reg(dma_frontend_pkg::REG_START, 64'h400, 8'hff);
    wait_chain_done(9);
    read_reg(dma_frontend_pkg::REG_STATUS, rdata);
    chk.final_checks();
    chk.end_test();

    $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
             chk.tests_passed, chk.tests_failed, chk.check_count, chk.error_count);
    if (chk.error_count == 0 && chk.tests_failed == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog timeout: the descriptor chains did not complete in time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/dma_frontend_pkg.sv
hw/sync_fifo.sv
hw/dma_csr.sv
hw/descriptor_fetch.sv
hw/descriptor_writeback.sv
hw/dma_frontend.sv
test/frontend_checker.sv
test/tb_dma_frontend.sv
